// ==== mat_pkg.sv ====
// ------------------------------------------------------------------
// Matrix data package: dimensions, derived sizes and packed types
// for elements, rows, slices and column chunks
// ------------------------------------------------------------------
package mat_pkg;

    // Fixed matrix shape
    localparam int elem_w     = 16;
    localparam int mat_rows   = 8;
    localparam int mat_cols   = 8;
    localparam int block_size = 2;
    localparam int num_cores  = 2;

    // Slicing of the frame
    localparam int slice_rows       = block_size * num_cores;
    localparam int chunks_per_slice = mat_cols / block_size;
    localparam int slices_per_frame = mat_rows / slice_rows;
    localparam int last_slice_base  = (slices_per_frame - 1) * slice_rows;

    // Index widths
    localparam int row_addr_w  = $clog2(mat_rows);
    localparam int slice_idx_w = $clog2(slice_rows);
    localparam int chunk_idx_w = $clog2(chunks_per_slice);
    localparam int col_idx_w   = $clog2(mat_cols);

    typedef logic [elem_w-1:0] elem_t;

    // Column 0 sits in the top bits
    typedef elem_t [0:mat_cols-1] row_t;

    // Slice row 0 sits in the top bits
    typedef row_t [0:slice_rows-1] slice_t;

    // One lane is a block of adjacent elements from one row
    typedef elem_t [0:block_size-1] lane_t;

    // Slice row 0 drives the top lane
    typedef lane_t [0:slice_rows-1] chunk_t;

endpackage

// ==== seq_pkg.sv ====
// ------------------------------------------------------------------
// Sequencing package: FSM state encodings of the three stages
// ------------------------------------------------------------------
package seq_pkg;

    // Row writer
    typedef enum logic {
        wr_idle,
        wr_fill
    } wr_state_t;

    // Slice reader
    typedef enum logic [1:0] {
        rd_idle,
        rd_read,
        rd_wait_hand,
        rd_done
    } rd_state_t;

    // Chunk serializer
    typedef enum logic {
        ser_idle,
        ser_emit
    } ser_state_t;

endpackage

// ==== ram_1w1r.sv ====
// ------------------------------------------------------------------
// Row buffer RAM, one write port and one registered read port
// ------------------------------------------------------------------
`timescale 1ns/1ps

module ram_1w1r (
    input  logic                          clk,
    input  logic                          we,
    input  logic [mat_pkg::row_addr_w-1:0] write_addr,
    input  logic [mat_pkg::row_addr_w-1:0] read_addr,
    input  mat_pkg::row_t                 din,
    output mat_pkg::row_t                 dout
);
    import mat_pkg::*;

    row_t mem [mat_rows];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // Data shows up one cycle after the address
    always_ff @(posedge clk) begin
        dout <= mem[read_addr];
    end

endmodule

// ==== row_writer.sv ====
// ------------------------------------------------------------------
// Fill stage: counts incoming rows into the RAM write port and
// flags a complete frame
// ------------------------------------------------------------------
`timescale 1ns/1ps

module row_writer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           en,
    input  logic                           frame_busy,
    input  mat_pkg::row_t                  in_row,
    output logic                           we,
    output logic [mat_pkg::row_addr_w-1:0] write_addr,
    output mat_pkg::row_t                  din,
    output logic                           fill_done
);
    import mat_pkg::*;
    import seq_pkg::*;

    wr_state_t             state;
    logic [row_addr_w-1:0] row_cnt;
    logic                  last_wr;
    logic                  accept;

    // Also blocked while the last row is still on its way to the RAM
    assign accept = en && !frame_busy && !last_wr && !fill_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= wr_idle;
            row_cnt   <= '0;
            we        <= 1'b0;
            last_wr   <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            we        <= accept;
            last_wr   <= 1'b0;
            fill_done <= last_wr;
            case (state)
                wr_idle: begin
                    if (accept) begin
                        row_cnt <= row_cnt + 1'b1;
                        state   <= wr_fill;
                    end
                end
                wr_fill: begin
                    if (accept) begin
                        if (row_cnt == row_addr_w'(mat_rows - 1)) begin
                            row_cnt <= '0;
                            last_wr <= 1'b1;
                            state   <= wr_idle;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_addr <= row_cnt;
            din        <= in_row;
        end
    end

endmodule

// ==== slice_reader.sv ====
// ------------------------------------------------------------------
// Slice reader: fetches slice_rows consecutive RAM rows into a slice
// buffer and hands the slice over when the serializer is free
// ------------------------------------------------------------------
`timescale 1ns/1ps

module slice_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fill_done,
    input  logic                           ser_busy,
    output logic [mat_pkg::row_addr_w-1:0] read_addr,
    input  mat_pkg::row_t                  dout,
    output mat_pkg::slice_t                slice_data,
    output logic                           slice_load,
    output logic                           last_slice
);
    import mat_pkg::*;
    import seq_pkg::*;

    rd_state_t              state;
    logic [row_addr_w-1:0]  slice_base;
    logic [slice_idx_w-1:0] row_idx;
    logic [slice_idx_w-1:0] row_idx_d;
    logic                   rd_valid_d;
    logic                   buf_full;
    slice_t                 slice_buf;

    assign read_addr = slice_base + row_addr_w'(row_idx);

    // Handover only with a complete buffer and an idle serializer
    assign slice_load = (state == rd_wait_hand) && buf_full && !ser_busy;
    assign last_slice = slice_load && (slice_base == row_addr_w'(last_slice_base));

    assign slice_data = slice_buf;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= rd_idle;
            slice_base <= '0;
            row_idx    <= '0;
            row_idx_d  <= '0;
            rd_valid_d <= 1'b0;
            buf_full   <= 1'b0;
        end else begin
            // Tracks which slice row the RAM returns next cycle
            rd_valid_d <= (state == rd_read);
            row_idx_d  <= row_idx;

            if (rd_valid_d && (row_idx_d == slice_idx_w'(slice_rows - 1))) begin
                buf_full <= 1'b1;
            end

            case (state)
                rd_idle: begin
                    if (fill_done) begin
                        state <= rd_read;
                    end
                end
                rd_read: begin
                    row_idx <= row_idx + 1'b1;
                    if (row_idx == slice_idx_w'(slice_rows - 1)) begin
                        state <= rd_wait_hand;
                    end
                end
                rd_wait_hand: begin
                    if (slice_load) begin
                        buf_full <= 1'b0;
                        if (last_slice) begin
                            slice_base <= '0;
                            state      <= rd_done;
                        end else begin
                            slice_base <= slice_base + row_addr_w'(slice_rows);
                            state      <= rd_read;
                        end
                    end
                end
                rd_done: begin
                    state <= rd_idle;
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // Slice buffer, one row per returning RAM word
    always_ff @(posedge clk) begin
        if (rd_valid_d) begin
            slice_buf[row_idx_d] <= dout;
        end
    end

endmodule

// ==== chunk_serializer.sv ====
// ------------------------------------------------------------------
// Chunk serializer: holds one slice and emits its column chunks,
// one per cycle, flagging the end of the slice and of the frame
// ------------------------------------------------------------------
`timescale 1ns/1ps

module chunk_serializer (
    input  logic            clk,
    input  logic            rst_n,
    input  mat_pkg::slice_t slice_data,
    input  logic            slice_load,
    input  logic            last_slice,
    output logic            ser_busy,
    output mat_pkg::chunk_t out_chunk,
    output logic            chunk_valid,
    output logic            slice_done,
    output logic            frame_done
);
    import mat_pkg::*;
    import seq_pkg::*;

    ser_state_t             state;
    slice_t                 slice_q;
    logic [chunk_idx_w-1:0] chunk_cnt;
    logic                   last_q;
    logic                   last_chunk;
    logic [col_idx_w-1:0]   col_base;

    assign ser_busy    = (state == ser_emit);
    assign chunk_valid = (state == ser_emit);
    assign last_chunk  = (state == ser_emit) &&
                         (chunk_cnt == chunk_idx_w'(chunks_per_slice - 1));
    assign slice_done  = last_chunk;
    assign frame_done  = last_chunk && last_q;

    // First column of the current chunk
    assign col_base = col_idx_w'(chunk_cnt) * col_idx_w'(block_size);

    always_comb begin
        for (int r = 0; r < slice_rows; r++) begin
            for (int e = 0; e < block_size; e++) begin
                out_chunk[r][e] = slice_q[r][col_base + col_idx_w'(e)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ser_idle;
            chunk_cnt <= '0;
            last_q    <= 1'b0;
        end else begin
            case (state)
                ser_idle: begin
                    if (slice_load) begin
                        chunk_cnt <= '0;
                        last_q    <= last_slice;
                        state     <= ser_emit;
                    end
                end
                ser_emit: begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (last_chunk) begin
                        state <= ser_idle;
                    end
                end
                default: state <= ser_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (slice_load) begin
            slice_q <= slice_data;
        end
    end

endmodule

// ==== n2r_buffer.sv ====
// ------------------------------------------------------------------
// Row-major to chunk-major reorder buffer for the multiply array
// ------------------------------------------------------------------
`timescale 1ns/1ps

module n2r_buffer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  mat_pkg::row_t   in_row,
    output mat_pkg::chunk_t out_chunk,
    output logic            chunk_valid,
    output logic            slice_done,
    output logic            frame_done
);
    import mat_pkg::*;

    logic                  we;
    logic [row_addr_w-1:0] write_addr;
    logic [row_addr_w-1:0] read_addr;
    row_t                  din;
    row_t                  dout;
    logic                  fill_done;
    slice_t                slice_data;
    logic                  slice_load;
    logic                  last_slice;
    logic                  ser_busy;
    logic                  frame_busy;

    // Frame in flight between fill and last chunk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_busy <= 1'b0;
        end else if (fill_done) begin
            frame_busy <= 1'b1;
        end else if (frame_done) begin
            frame_busy <= 1'b0;
        end
    end

    row_writer row_writer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .frame_busy (frame_busy),
        .in_row     (in_row),
        .we         (we),
        .write_addr (write_addr),
        .din        (din),
        .fill_done  (fill_done)
    );

    ram_1w1r ram_1w1r_i (
        .clk        (clk),
        .we         (we),
        .write_addr (write_addr),
        .read_addr  (read_addr),
        .din        (din),
        .dout       (dout)
    );

    slice_reader slice_reader_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_done  (fill_done),
        .ser_busy   (ser_busy),
        .read_addr  (read_addr),
        .dout       (dout),
        .slice_data (slice_data),
        .slice_load (slice_load),
        .last_slice (last_slice)
    );

    chunk_serializer chunk_serializer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .slice_data  (slice_data),
        .slice_load  (slice_load),
        .last_slice  (last_slice),
        .ser_busy    (ser_busy),
        .out_chunk   (out_chunk),
        .chunk_valid (chunk_valid),
        .slice_done  (slice_done),
        .frame_done  (frame_done)
    );

endmodule

// ==== n2r_buffer_tb.sv ====
// ------------------------------------------------------------------
// Testbench for the reorder buffer: table-driven frames, chunk and
// flag checks against the lane rule, cycle-limited run
// ------------------------------------------------------------------
`timescale 1ns/1ps

module n2r_buffer_tb;
    import mat_pkg::*;

    localparam int num_frames       = 2;
    localparam int reset_cycles     = 3;
    localparam int drain_rows       = 6;
    localparam int chunks_per_frame = slices_per_frame * chunks_per_slice;
    localparam int total_chunks     = num_frames * chunks_per_frame;
    localparam int timeout_cycles   =
        4 * (num_frames * (mat_rows + slices_per_frame * 9) + reset_cycles);
    localparam logic [31:0] seed    = 32'h2655_1f0c;

    logic   clk;
    logic   rst_n;
    logic   en;
    row_t   in_row;
    chunk_t out_chunk;
    logic   chunk_valid;
    logic   slice_done;
    logic   frame_done;

    // Stimulus rows and the chunks they must turn into
    row_t   stim_rows [num_frames][mat_rows];
    chunk_t exp_chunks [total_chunks];

    int chunk_count = 0;
    int cycles      = 0;

    n2r_buffer n2r_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .in_row      (in_row),
        .out_chunk   (out_chunk),
        .chunk_valid (chunk_valid),
        .slice_done  (slice_done),
        .frame_done  (frame_done)
    );

    always #20 clk = ~clk;

    task stop_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task check_chunk(chunk_t got, chunk_t exp, int idx);
        if (got !== exp) begin
            $display("mismatch at time %0t: chunk %0d got %h expected %h",
                     $time, idx, got, exp);
            stop_run();
        end
    endtask

    task check_flag(string name, logic got, logic exp, int idx);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s at chunk %0d got %b expected %b",
                     $time, name, idx, got, exp);
            stop_run();
        end
    endtask

    function automatic logic ends_slice(int idx);
        return (idx % chunks_per_slice) == (chunks_per_slice - 1);
    endfunction

    function automatic logic ends_frame(int idx);
        return (idx % chunks_per_frame) == (chunks_per_frame - 1);
    endfunction

    function automatic row_t random_row();
        row_t row;
        for (int c = 0; c < mat_cols; c++) begin
            row[c] = elem_t'($urandom());
        end
        return row;
    endfunction

    // Frame 0 from row and column, frame 1 random
    task build_tables();
        int idx;
        for (int r = 0; r < mat_rows; r++) begin
            for (int c = 0; c < mat_cols; c++) begin
                stim_rows[0][r][c] = elem_t'((r + 1) * 256 + c);
            end
            stim_rows[1][r] = random_row();
        end
        // Lane r of chunk c takes columns block_size*c onward of slice row r
        for (int f = 0; f < num_frames; f++) begin
            for (int s = 0; s < slices_per_frame; s++) begin
                for (int c = 0; c < chunks_per_slice; c++) begin
                    idx = f * chunks_per_frame + s * chunks_per_slice + c;
                    for (int r = 0; r < slice_rows; r++) begin
                        for (int e = 0; e < block_size; e++) begin
                            exp_chunks[idx][r][e] =
                                stim_rows[f][s * slice_rows + r][c * block_size + e];
                        end
                    end
                end
            end
        end
    endtask

    // Outputs sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        if (rst_n) begin
            if (chunk_valid === 1'b1) begin
                if (chunk_count >= total_chunks) begin
                    $display("chunk_valid went high after all expected chunks were seen");
                    stop_run();
                end else begin
                    check_chunk(out_chunk, exp_chunks[chunk_count], chunk_count);
                    check_flag("slice_done", slice_done, ends_slice(chunk_count),
                               chunk_count);
                    check_flag("frame_done", frame_done, ends_frame(chunk_count),
                               chunk_count);
                    chunk_count = chunk_count + 1;
                end
            end else begin
                check_flag("chunk_valid", chunk_valid, 1'b0, chunk_count);
                check_flag("slice_done", slice_done, 1'b0, chunk_count);
                check_flag("frame_done", frame_done, 1'b0, chunk_count);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            stop_run();
        end
    end

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        en     = 1'b0;
        in_row = '0;
        void'($urandom(seed));
        build_tables();

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // Idle rows with en low must leave the outputs quiet
        repeat (4) begin
            @(posedge clk);
            in_row <= random_row();
        end

        for (int f = 0; f < num_frames; f++) begin
            for (int r = 0; r < mat_rows; r++) begin
                @(posedge clk);
                en     <= 1'b1;
                in_row <= stim_rows[f][r];
            end
            // Offered while the frame drains, so never stored
            for (int j = 0; j < drain_rows; j++) begin
                @(posedge clk);
                en     <= 1'b1;
                in_row <= random_row();
            end
            @(posedge clk);
            en <= 1'b0;
            while (chunk_count < (f + 1) * chunks_per_frame) begin
                @(posedge clk);
            end
        end

        // Room for any stray chunk to show up
        repeat (10) @(posedge clk);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
mat_pkg.sv
seq_pkg.sv
ram_1w1r.sv
row_writer.sv
slice_reader.sv
chunk_serializer.sv
n2r_buffer.sv
n2r_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the n2r_buffer testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module n2r_buffer_tb -o n2r_sim \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/n2r_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "Test OK" && exit 0 || exit 1
